// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// Data path width
	localparam int XLEN    = 32;
	localparam int SHAMT_W = $clog2(XLEN);	// Shift amount bits taken from op_b

	typedef logic [XLEN-1:0] word_t;	// Register operand / result
	typedef logic [31:0]     inst_t;	// Raw instruction word
	typedef logic [6:0]      opcode_t;
	typedef logic [2:0]      funct3_t;
	typedef logic [6:0]      funct7_t;

	// Major opcodes handled by the execute stage
	localparam opcode_t OPC_OP     = 7'h33;	// R-type, incl. M extension
	localparam opcode_t OPC_BRANCH = 7'h63;

	// funct7 variants of OPC_OP
	localparam funct7_t F7_BASE   = 7'h00;
	localparam funct7_t F7_ALT    = 7'h20;	// SUB, SRA
	localparam funct7_t F7_MULDIV = 7'h01;

	// Branch funct3
	localparam funct3_t F3_BEQ  = 3'h0;
	localparam funct3_t F3_BNE  = 3'h1;
	localparam funct3_t F3_BLT  = 3'h4;
	localparam funct3_t F3_BGE  = 3'h5;
	localparam funct3_t F3_BLTU = 3'h6;
	localparam funct3_t F3_BGEU = 3'h7;

	// M extension divide funct3, multiplies (0..3) not supported
	localparam funct3_t F3_DIV  = 3'h4;
	localparam funct3_t F3_DIVU = 3'h5;
	localparam funct3_t F3_REM  = 3'h6;
	localparam funct3_t F3_REMU = 3'h7;

endpackage

`default_nettype wire

// File: design/exe_ctrl_pkg.sv
`default_nettype none

package exe_ctrl_pkg;

	import rv_isa_pkg::*;

	// One quotient bit per RUN cycle
	localparam int DIV_STEPS = XLEN;
	localparam int DIV_CNT_W = $clog2(DIV_STEPS);

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_op_e;

	typedef enum logic [1:0] {
		DIV  = 2'd0,
		DIVU = 2'd1,
		REM  = 2'd2,
		REMU = 2'd3
	} div_op_e;

	typedef enum logic [2:0] {
		BR_EQ  = 3'd0,
		BR_NE  = 3'd1,
		BR_LT  = 3'd2,
		BR_GE  = 3'd3,
		BR_LTU = 3'd4,
		BR_GEU = 3'd5
	} br_cond_e;

	// Which part produces the outcome
	typedef enum logic [1:0] {
		KIND_ALU     = 2'd0,
		KIND_DIV     = 2'd1,
		KIND_BRANCH  = 2'd2,
		KIND_ILLEGAL = 2'd3
	} op_kind_e;

	// Decoded control, 12 bits
	typedef struct packed {
		logic     go;		// Accepted issue this cycle
		op_kind_e kind;
		alu_op_e  alu_op;
		div_op_e  div_op;
		br_cond_e br_cond;
	} exe_ctrl_t;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		FIX  = 2'd2	// Sign fix and result select
	} div_state_e;

endpackage

`default_nettype wire

// File: design/op_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module op_decoder (
	input  logic                    issue,
	input  rv_isa_pkg::inst_t       inst,
	input  logic                    busy,
	output exe_ctrl_pkg::exe_ctrl_t ctrl
);

	import rv_isa_pkg::*;
	import exe_ctrl_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		ctrl         = '0;
		ctrl.kind    = KIND_ILLEGAL;	// Anything not matched below
		ctrl.go      = issue && !busy;	// Issue during a divide is dropped
		case (opcode)
			OPC_OP: begin
				case (funct7)
					F7_BASE: begin
						ctrl.kind = KIND_ALU;
						case (funct3)
							3'h0: ctrl.alu_op = ALU_ADD;
							3'h1: ctrl.alu_op = ALU_SLL;
							3'h2: ctrl.alu_op = ALU_SLT;
							3'h3: ctrl.alu_op = ALU_SLTU;
							3'h4: ctrl.alu_op = ALU_XOR;
							3'h5: ctrl.alu_op = ALU_SRL;
							3'h6: ctrl.alu_op = ALU_OR;
							default: ctrl.alu_op = ALU_AND;
						endcase
					end
					F7_ALT: begin
						// Only SUB and SRA exist here
						if (funct3 == 3'h0) begin
							ctrl.kind   = KIND_ALU;
							ctrl.alu_op = ALU_SUB;
						end else if (funct3 == 3'h5) begin
							ctrl.kind   = KIND_ALU;
							ctrl.alu_op = ALU_SRA;
						end
					end
					F7_MULDIV: begin
						ctrl.kind = KIND_DIV;
						case (funct3)
							F3_DIV:  ctrl.div_op = DIV;
							F3_DIVU: ctrl.div_op = DIVU;
							F3_REM:  ctrl.div_op = REM;
							F3_REMU: ctrl.div_op = REMU;
							default: ctrl.kind = KIND_ILLEGAL;	// MUL family
						endcase
					end
					default: ;
				endcase
			end
			OPC_BRANCH: begin
				ctrl.kind = KIND_BRANCH;
				case (funct3)
					F3_BEQ:  ctrl.br_cond = BR_EQ;
					F3_BNE:  ctrl.br_cond = BR_NE;
					F3_BLT:  ctrl.br_cond = BR_LT;
					F3_BGE:  ctrl.br_cond = BR_GE;
					F3_BLTU: ctrl.br_cond = BR_LTU;
					F3_BGEU: ctrl.br_cond = BR_GEU;
					default: ctrl.kind = KIND_ILLEGAL;	// funct3 2 and 3 reserved
				endcase
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  rv_isa_pkg::word_t       op_a,
	input  rv_isa_pkg::word_t       op_b,
	input  exe_ctrl_pkg::exe_ctrl_t ctrl,
	output rv_isa_pkg::word_t       alu_res,
	output logic                    br_taken
);

	import rv_isa_pkg::*;
	import exe_ctrl_pkg::*;

	logic [SHAMT_W-1:0] shamt;
	logic               z;		// Operands equal
	logic               less_s;	// Signed a < b
	logic               less_u;	// Unsigned a < b
	logic               cond;

	assign shamt  = op_b[SHAMT_W-1:0];
	assign z      = (op_a == op_b);
	assign less_s = ($signed(op_a) < $signed(op_b));
	assign less_u = (op_a < op_b);

	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD:  alu_res = op_a + op_b;
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_SLL:  alu_res = op_a << shamt;
			ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, less_s};
			ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, less_u};
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SRL:  alu_res = op_a >> shamt;
			ALU_SRA:  alu_res = word_t'($signed(op_a) >>> shamt);	// Sign fill
			ALU_OR:   alu_res = op_a | op_b;
			ALU_AND:  alu_res = op_a & op_b;
			default:  alu_res = '0;
		endcase
	end

	// Branch condition from the three flags
	always_comb begin
		case (ctrl.br_cond)
			BR_EQ:   cond = z;
			BR_NE:   cond = !z;
			BR_LT:   cond = less_s;
			BR_GE:   cond = !less_s;
			BR_LTU:  cond = less_u;
			BR_GEU:  cond = !less_u;
			default: cond = 1'b0;
		endcase
	end

	// Only a branch may report taken
	assign br_taken = cond && (ctrl.kind == KIND_BRANCH);

endmodule

`default_nettype wire

// File: design/divider.sv
`timescale 1ns/10ps
`default_nettype none

module divider (
	input  logic                    clk,
	input  logic                    arst_n,
	input  rv_isa_pkg::word_t       op_a,
	input  rv_isa_pkg::word_t       op_b,
	input  exe_ctrl_pkg::exe_ctrl_t ctrl,
	output logic                    busy,
	output logic                    div_done,
	output rv_isa_pkg::word_t       div_res
);

	import rv_isa_pkg::*;
	import exe_ctrl_pkg::*;

	div_state_e           state;
	logic [DIV_CNT_W-1:0] step;		// Quotient bit counter
	word_t                rem_q;	// Partial remainder
	word_t                quo_q;	// Dividend shifting out, quotient shifting in
	word_t                dvs_q;	// Divisor magnitude
	logic                 neg_quo;
	logic                 neg_rem;
	logic                 want_rem;
	logic                 start;
	logic                 signed_op;
	logic                 a_neg;
	logic                 b_neg;
	word_t                a_mag;
	word_t                b_mag;
	logic [XLEN:0]        rem_sh;
	logic [XLEN:0]        trial;

	assign start     = ctrl.go && (ctrl.kind == KIND_DIV);
	assign signed_op = (ctrl.div_op == DIV) || (ctrl.div_op == REM);
	assign a_neg     = signed_op && op_a[XLEN-1];
	assign b_neg     = signed_op && op_b[XLEN-1];
	assign a_mag     = a_neg ? -op_a : op_a;	// 0x8000_0000 stays as is, fine unsigned
	assign b_mag     = b_neg ? -op_b : op_b;

	// Restoring step, one extra bit holds the borrow
	assign rem_sh = {rem_q, quo_q[XLEN-1]};
	assign trial  = rem_sh - {1'b0, dvs_q};

	assign busy = (state != IDLE);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= IDLE;
			step     <= '0;
			div_done <= 1'b0;
		end else begin
			div_done <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						step  <= '0;
						state <= (op_b == '0) ? FIX : RUN;	// Zero divisor skips RUN
					end
				end
				RUN: begin
					step <= step + 1'b1;
					if (step == DIV_CNT_W'(DIV_STEPS - 1))
						state <= FIX;
				end
				FIX: begin
					div_done <= 1'b1;	// busy already low with this pulse
					state    <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (start) begin
					want_rem <= (ctrl.div_op == REM) || (ctrl.div_op == REMU);
					dvs_q    <= b_mag;
					if (op_b == '0) begin
						// RISC-V divide by zero results, no sign fix
						quo_q   <= '1;
						rem_q   <= op_a;
						neg_quo <= 1'b0;
						neg_rem <= 1'b0;
					end else begin
						quo_q   <= a_mag;
						rem_q   <= '0;
						neg_quo <= a_neg ^ b_neg;
						neg_rem <= a_neg;	// Remainder follows dividend
					end
				end
			end
			RUN: begin
				if (!trial[XLEN]) begin
					rem_q <= trial[XLEN-1:0];
					quo_q <= {quo_q[XLEN-2:0], 1'b1};
				end else begin
					rem_q <= rem_sh[XLEN-1:0];	// Restore
					quo_q <= {quo_q[XLEN-2:0], 1'b0};
				end
			end
			FIX: begin
				if (want_rem)
					div_res <= neg_rem ? -rem_q : rem_q;
				else
					div_res <= neg_quo ? -quo_q : quo_q;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: design/result_merge.sv
`timescale 1ns/10ps
`default_nettype none

module result_merge (
	input  logic                    clk,
	input  logic                    arst_n,
	input  exe_ctrl_pkg::exe_ctrl_t ctrl,
	input  rv_isa_pkg::word_t       alu_res,
	input  logic                    br_taken,
	input  logic                    div_done,
	input  rv_isa_pkg::word_t       div_res,
	output rv_isa_pkg::word_t       result,
	output logic                    result_valid,
	output logic                    branch_taken,
	output logic                    illegal
);

	import rv_isa_pkg::*;
	import exe_ctrl_pkg::*;

	op_kind_e kind_q;	// Kind of the last accepted issue
	word_t    res_q;
	logic     valid_q;
	logic     br_q;
	logic     ill_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			kind_q  <= KIND_ALU;
			res_q   <= '0;
			valid_q <= 1'b0;
			br_q    <= 1'b0;
			ill_q   <= 1'b0;
		end else begin
			valid_q <= ctrl.go && (ctrl.kind != KIND_DIV);	// Divide reports via div_done
			if (ctrl.go) begin
				kind_q <= ctrl.kind;
				res_q  <= (ctrl.kind == KIND_ALU) ? alu_res : '0;	// Branch, illegal give zero
				br_q   <= br_taken;
				ill_q  <= (ctrl.kind == KIND_ILLEGAL);
			end
		end
	end

	// Divider holds its result, so it is passed straight through
	assign result       = (kind_q == KIND_DIV) ? div_res : res_q;
	assign result_valid = valid_q || div_done;
	assign branch_taken = br_q;
	assign illegal      = ill_q;

endmodule

`default_nettype wire

// File: design/exe_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exe_unit (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              issue,		// 1-cycle strobe
	input  rv_isa_pkg::inst_t inst,
	input  rv_isa_pkg::word_t op_a,
	input  rv_isa_pkg::word_t op_b,
	output logic              busy,			// Divide in progress
	output logic              result_valid,
	output rv_isa_pkg::word_t result,
	output logic              branch_taken,
	output logic              illegal
);

	import rv_isa_pkg::*;
	import exe_ctrl_pkg::*;

	exe_ctrl_t ctrl;
	word_t     alu_res;
	word_t     div_res;
	logic      br_taken;
	logic      div_done;

	op_decoder i_op_decoder (
		.issue (issue),
		.inst  (inst),
		.busy  (busy),		// Back-pressure on issue
		.ctrl  (ctrl)
	);

	alu i_alu (
		.op_a     (op_a),
		.op_b     (op_b),
		.ctrl     (ctrl),
		.alu_res  (alu_res),
		.br_taken (br_taken)
	);

	divider i_divider (
		.clk      (clk),
		.arst_n   (arst_n),
		.op_a     (op_a),
		.op_b     (op_b),
		.ctrl     (ctrl),
		.busy     (busy),
		.div_done (div_done),
		.div_res  (div_res)
	);

	result_merge i_result_merge (
		.clk          (clk),
		.arst_n       (arst_n),
		.ctrl         (ctrl),
		.alu_res      (alu_res),
		.br_taken     (br_taken),
		.div_done     (div_done),
		.div_res      (div_res),
		.result       (result),
		.result_valid (result_valid),
		.branch_taken (branch_taken),
		.illegal      (illegal)
	);

endmodule

`default_nettype wire

// File: dv/exe_checker.sv
`timescale 1ns/10ps
`default_nettype none

module exe_checker (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              issue,
	input  rv_isa_pkg::inst_t inst,
	input  logic              busy,
	input  logic              result_valid,
	input  rv_isa_pkg::word_t result,
	input  logic              branch_taken,
	input  logic              illegal,
	output int                n_expected,
	output int                n_seen,
	output int                n_wrong,
	output int                n_extra
);

	import rv_isa_pkg::*;

	localparam int COLS      = 6;	// inst, op_a, op_b, result, branch_taken, illegal
	localparam int MAX_ITEMS = 64;

	word_t gold [0:COLS*MAX_ITEMS-1];
	int    expected  = 0;
	int    seen      = 0;	// Results compared so far
	int    wrong     = 0;
	int    extra     = 0;
	logic  div_taken = 1'b0;	// Divide accepted at the coming edge

	assign n_expected = expected;
	assign n_seen     = seen;
	assign n_wrong    = wrong;
	assign n_extra    = extra;

	// Marks words the file never wrote
	function automatic word_t fill_word(input int addr);
		return 32'hf1e1_0000 | word_t'(addr);
	endfunction

	// OP opcode with M extension funct7 and funct3 4 to 7
	function automatic logic is_divide(input inst_t ins);
		return ins[6:0] == OPC_OP && ins[31:25] == F7_MULDIV && ins[14];
	endfunction

	task automatic check_value(input string field, input int item, input word_t exp_val,
			input word_t act_val);
		if (exp_val !== act_val) begin
			wrong++;
			$display("ERROR item %0d (inst %08h) %s: expected %08h, actual %08h",
				item, gold[item*COLS], field, exp_val, act_val);
		end
	endtask

	task automatic check_reset_value(input string field, input word_t act_val);
		if (act_val !== '0) begin
			wrong++;
			$display("ERROR reset %s: expected %08h, actual %08h", field, 32'h0, act_val);
		end
	endtask

	initial begin
		for (int i = 0; i < COLS*MAX_ITEMS; i++)
			gold[i] = fill_word(i);
		$readmemh("dv/exe_golden.txt", gold);
		// Count lines up to the first untouched instruction slot
		while (expected < MAX_ITEMS && gold[expected*COLS] != fill_word(expected*COLS))
			expected++;
	end

	// Registered outputs settle before the falling edge
	always @(negedge clk) begin
		if (!arst_n) begin
			// All outputs low in reset
			check_reset_value("busy", word_t'(busy));
			check_reset_value("result_valid", word_t'(result_valid));
			check_reset_value("result", result);
			check_reset_value("branch_taken", word_t'(branch_taken));
			check_reset_value("illegal", word_t'(illegal));
			div_taken = 1'b0;
		end else begin
			if (div_taken && !busy) begin
				wrong++;
				$display("ERROR busy after divide issue: expected 1, actual 0");
			end
			div_taken = issue && !busy && is_divide(inst);	// busy due one cycle later
			if (result_valid) begin
				if (seen >= expected) begin
					extra++;
					$display("Unexpected result %08h appeared after all golden lines were used",
						result);
				end else begin
					check_value("result", seen, gold[seen*COLS+3], result);
					check_value("branch_taken", seen, gold[seen*COLS+4], word_t'(branch_taken));
					check_value("illegal", seen, gold[seen*COLS+5], word_t'(illegal));
					check_value("busy", seen, '0, word_t'(busy));	// Low with every pulse
					seen++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/tb_exe_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exe_unit;

	import rv_isa_pkg::*;

	localparam int COLS      = 6;	// Golden line layout shared with the checker
	localparam int MAX_ITEMS = 64;
	localparam int WAIT_MAX  = 100;	// Cycles allowed per wait

	logic  clk = 1'b0;
	logic  arst_n;
	logic  issue;
	inst_t inst;
	word_t op_a;
	word_t op_b;
	logic  busy;
	logic  result_valid;
	word_t result;
	logic  branch_taken;
	logic  illegal;

	int n_expected;
	int n_seen;
	int n_wrong;
	int n_extra;
	int timeouts = 0;

	word_t       gold [0:COLS*MAX_ITEMS-1];
	logic [31:0] lfsr = 32'h7f7e_af5a;

	always #5 clk = ~clk;	// 10 ns period

	exe_unit i_exe_unit (
		.clk          (clk),
		.arst_n       (arst_n),
		.issue        (issue),
		.inst         (inst),
		.op_a         (op_a),
		.op_b         (op_b),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result),
		.branch_taken (branch_taken),
		.illegal      (illegal)
	);

	exe_checker i_exe_checker (
		.clk          (clk),
		.arst_n       (arst_n),
		.issue        (issue),
		.inst         (inst),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result),
		.branch_taken (branch_taken),
		.illegal      (illegal),
		.n_expected   (n_expected),
		.n_seen       (n_seen),
		.n_wrong      (n_wrong),
		.n_extra      (n_extra)
	);

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic logic is_divide(input inst_t ins);
		return ins[6:0] == OPC_OP && ins[31:25] == F7_MULDIV && ins[14];	// funct3 4..7
	endfunction

	// Ends on a rising edge once busy is low
	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge clk);
		while (busy && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			$display("Timeout: busy stayed high for %0d cycles", WAIT_MAX);
			timeouts++;
		end
		@(posedge clk);
	endtask

	task automatic wait_results();
		int n;
		n = 0;
		while (n_seen < n_expected && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		if (n_seen < n_expected) begin
			$display("Results went missing: %0d of %0d golden lines never reported",
				n_expected - n_seen, n_expected);
			timeouts++;
		end
	endtask

	// Entered and left on a rising edge
	task automatic send_item(input int idx);
		inst_t       ins;
		logic [31:0] gap;
		logic [31:0] r;
		ins = gold[idx*COLS];
		take_bits(2, gap);
		if (gap != 0) begin
			issue <= 1'b0;
			repeat (gap) @(posedge clk);	// 1 to 3 idle cycles
		end
		issue <= 1'b1;
		inst  <= ins;
		op_a  <= gold[idx*COLS+1];
		op_b  <= gold[idx*COLS+2];
		take_bits(1, r);
		@(posedge clk);	// DUT accepts the issue here
		// ALU kinds leave issue high so the next item may follow directly
		if (is_divide(ins)) begin
			// Junk in the busy cycle after a divide issue must be dropped
			if (r[0]) begin
				take_bits(32, r);
				inst <= r;
				take_bits(32, r);
				op_a <= r;
				take_bits(32, r);
				op_b <= r;
				@(posedge clk);
			end
			issue <= 1'b0;
			wait_idle();
		end
	endtask

	initial begin
		arst_n = 1'b0;
		issue  = 1'b0;
		inst   = '0;
		op_a   = '0;
		op_b   = '0;
		$readmemh("dv/exe_golden.txt", gold);
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < n_expected && timeouts == 0; i++)
			send_item(i);
		issue <= 1'b0;	// Drop the strobe after the last item
		if (timeouts == 0)
			wait_results();
		repeat (10) @(posedge clk);	// Room for stray pulses
		$display("Results %0d of %0d, wrong values %0d, unexpected results %0d, timeouts %0d",
			n_seen, n_expected, n_wrong, n_extra, timeouts);
		if (n_wrong == 0 && n_extra == 0 && timeouts == 0 && n_expected > 0 &&
				n_seen == n_expected)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/exe_golden.txt
// inst op_a op_b result branch_taken illegal, all hex
// One instruction per line, issued and checked in this order
003100b3 7fffffff 00000001 80000000 0 0  // add, wraps to most negative
403100b3 00000005 00000007 fffffffe 0 0  // sub
003110b3 00000003 00000024 00000030 0 0  // sll, only low 5 bits of op_b
003120b3 fffffff0 00000001 00000001 0 0  // slt, -16 < 1
003130b3 fffffff0 00000001 00000000 0 0  // sltu, same operands
003140b3 0f0f00ff ff00ff00 f00fffff 0 0  // xor
003150b3 80000000 00000004 08000000 0 0  // srl
403150b3 80000000 00000004 f8000000 0 0  // sra
003160b3 00f000f0 0000ff00 00f0fff0 0 0  // or
003170b3 12345678 0000ffff 00005678 0 0  // and
00310063 00000005 00000005 00000000 1 0  // beq equal
00311063 00000005 00000005 00000000 0 0  // bne equal
00314063 ffffffff 00000001 00000000 1 0  // blt, -1 < 1
00315063 ffffffff 00000001 00000000 0 0  // bge
00316063 ffffffff 00000001 00000000 0 0  // bltu
00317063 ffffffff 00000001 00000000 1 0  // bgeu
023140b3 fffffff9 00000002 fffffffd 0 0  // div -7 / 2
023160b3 fffffff9 00000002 ffffffff 0 0  // rem, sign of dividend
023150b3 fffffff9 00000002 7ffffffc 0 0  // divu
023170b3 fffffff9 00000002 00000001 0 0  // remu
023160b3 00000007 fffffffe 00000001 0 0  // rem 7 / -2
023140b3 00000064 00000000 ffffffff 0 0  // div by zero
023170b3 00000064 00000000 00000064 0 0  // remu by zero
023160b3 fffffff9 00000000 fffffff9 0 0  // rem by zero, negative dividend
023140b3 80000000 ffffffff 80000000 0 0  // div overflow
023160b3 80000000 ffffffff 00000000 0 0  // rem overflow
00012083 00000001 00000002 00000000 0 1  // lw, not supported
023100b3 00000003 00000004 00000000 0 1  // mul, not supported

// File: files.f
design/rv_isa_pkg.sv
design/exe_ctrl_pkg.sv
design/op_decoder.sv
design/alu.sv
design/divider.sv
design/result_merge.sv
design/exe_unit.sv
dv/exe_checker.sv
dv/tb_exe_unit.sv

// File: Makefile
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary -f files.f --top-module tb_exe_unit -Mdir obj_dir -o tb_exe_unit

run: compile
	./obj_dir/tb_exe_unit > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "All checks passed" $(LOG); then \
		echo "Simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
